// File: flist.f
src/hbus_pkg.sv
src/hbus_ca_shifter.sv
src/hbus_read_capture.sv
src/hbus_sequencer.sv
src/hbus_ctrl.sv
testbench/hyperram_model.sv
testbench/tb_hbus_ctrl.sv

// File: src/hbus_ca_shifter.sv
`timescale 1ns/1ps

module hbus_ca_shifter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                load_i,
    input  logic                                step_i,
    input  hbus_pkg::hbus_req_t                 req_i,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     ca_word_o,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     wdata_o
);

    hbus_pkg::hbus_ca_t                     ca_build;
    logic [hbus_pkg::CA_WIDTH-1:0]          ca_q;
    logic [hbus_pkg::WORD_WIDTH-1:0]        wdata_q;

    // Command/address fields from the host request
    always_comb begin
        ca_build.rw           = req_i.rw;
        ca_build.addr_space   = req_i.reg_space;
        // Wrapped bursts only, single word
        ca_build.burst_linear = 1'b0;
        ca_build.row_col_hi   = req_i.adr[31:3];
        ca_build.reserved     = '0;
        ca_build.col_lo       = req_i.adr[2:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca_q    <= '0;
            wdata_q <= '0;
        end else if (load_i) begin
            ca_q    <= ca_build;
            wdata_q <= req_i.wdata;
        end else if (step_i) begin
            // Next word moves to the top
            ca_q <= {ca_q[hbus_pkg::CA_WIDTH-hbus_pkg::WORD_WIDTH-1:0],
                     {hbus_pkg::WORD_WIDTH{1'b0}}};
        end
    end

    assign ca_word_o = ca_q[hbus_pkg::CA_WIDTH-1 -: hbus_pkg::WORD_WIDTH];
    assign wdata_o   = wdata_q;

endmodule

// File: src/hbus_ctrl.sv
`timescale 1ns/1ps

module hbus_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    // Host side
    input  logic                                rrq_i,
    input  logic                                wrq_i,
    input  logic                                reg_space_i,
    input  logic [31:0]                         adr_i,
    input  logic [hbus_pkg::WORD_WIDTH-1:0]     wdata_i,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     rdata_o,
    output logic                                rdata_valid_o,
    output logic                                busy_o,
    output logic                                error_o,
    // Bus side, half rate
    output logic                                csn_o,
    output logic                                rstn_o,
    output logic                                clk_en_o,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     dq_o,
    output logic                                dq_oe_o,
    input  logic [hbus_pkg::WORD_WIDTH-1:0]     dq_i,
    input  logic [1:0]                          rwds_i
);

    hbus_pkg::hbus_req_t                    req;
    hbus_pkg::hbus_state_e                  state;
    logic [hbus_pkg::WORD_WIDTH-1:0]        ca_word;
    logic [hbus_pkg::WORD_WIDTH-1:0]        wdata;
    logic                                   load;
    logic                                   step;
    logic                                   read_en;
    logic                                   strobe;
    logic                                   timeout;
    logic                                   dq_sel_wdata;
    logic                                   data_phase;
    logic [hbus_pkg::RECOVERY_COUNT-1:0]    recovery_q;
    logic                                   rdata_valid_q;

    assign req = '{rw: rrq_i, reg_space: reg_space_i, adr: adr_i, wdata: wdata_i};

    hbus_sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .rrq_i          (rrq_i),
        .wrq_i          (wrq_i),
        .rwds_i         (rwds_i),
        .strobe_i       (strobe),
        .timeout_i      (timeout),
        .load_o         (load),
        .step_o         (step),
        .read_en_o      (read_en),
        .state_o        (state),
        .dq_sel_wdata_o (dq_sel_wdata),
        .clk_en_o       (clk_en_o),
        .dq_oe_o        (dq_oe_o)
    );

    hbus_ca_shifter u_ca_shifter (
        .clk       (clk),
        .rst       (rst),
        .load_i    (load),
        .step_i    (step),
        .req_i     (req),
        .ca_word_o (ca_word),
        .wdata_o   (wdata)
    );

    hbus_read_capture u_read_capture (
        .clk       (clk),
        .rst       (rst),
        .read_en_i (read_en),
        .rwds_i    (rwds_i),
        .dq_i      (dq_i),
        .rdata_o   (rdata_o),
        .strobe_o  (strobe),
        .timeout_o (timeout)
    );

    // Chip select low only while a transaction is on the bus
    assign csn_o   = !(state inside {hbus_pkg::COMMAND, hbus_pkg::LATENCY,
                                     hbus_pkg::READ, hbus_pkg::WRITE});
    assign rstn_o  = (state != hbus_pkg::RESET);
    assign error_o = (state == hbus_pkg::ERROR);

    assign dq_o = dq_sel_wdata ? wdata : ca_word;

    // Mirrors the recovery window that follows each read or write
    assign data_phase = (state == hbus_pkg::READ) || (state == hbus_pkg::WRITE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            recovery_q    <= '0;
            rdata_valid_q <= 1'b0;
        end else begin
            recovery_q    <= {recovery_q[hbus_pkg::RECOVERY_COUNT-2:0], data_phase};
            rdata_valid_q <= strobe;
        end
    end

    assign busy_o        = (state != hbus_pkg::IDLE) || (|recovery_q);
    assign rdata_valid_o = rdata_valid_q;

endmodule

// File: src/hbus_pkg.sv
package hbus_pkg;

    // Bus geometry
    localparam int DQ_WIDTH = 8;
    localparam int WORD_WIDTH = 2 * DQ_WIDTH;

    // Timing in clk cycles
    localparam int TACC_COUNT = 7;
    localparam int RESET_COUNT = 2;
    localparam int RECOVERY_COUNT = 2;
    localparam int TIMEOUT_COUNT = 15;

    // Counter widths
    localparam int SEQ_COUNT_W = $clog2(2 * TACC_COUNT + 1);
    localparam int TIMEOUT_W = $clog2(TIMEOUT_COUNT + 1);

    typedef logic [SEQ_COUNT_W-1:0] seq_count_t;
    typedef logic [TIMEOUT_W-1:0] timeout_count_t;

    // One host request as latched at the start of a transaction
    typedef struct packed {
        logic                  rw;
        logic                  reg_space;
        logic [31:0]           adr;
        logic [WORD_WIDTH-1:0] wdata;
    } hbus_req_t;

    // Command/address word, most significant field goes out first
    typedef struct packed {
        logic        rw;
        logic        addr_space;
        logic        burst_linear;
        logic [28:0] row_col_hi;
        logic [12:0] reserved;
        logic [2:0]  col_lo;
    } hbus_ca_t;

    localparam int CA_WIDTH = $bits(hbus_ca_t);

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        COMMAND,
        LATENCY,
        READ,
        WRITE,
        ERROR
    } hbus_state_e;

endpackage

// File: src/hbus_read_capture.sv
`timescale 1ns/1ps

module hbus_read_capture (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                read_en_i,
    input  logic [1:0]                          rwds_i,
    input  logic [hbus_pkg::WORD_WIDTH-1:0]     dq_i,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     rdata_o,
    output logic                                strobe_o,
    output logic                                timeout_o
);

    localparam hbus_pkg::timeout_count_t LAST_CYCLE =
        hbus_pkg::timeout_count_t'(hbus_pkg::TIMEOUT_COUNT - 1);

    hbus_pkg::timeout_count_t               wait_q;
    logic [hbus_pkg::WORD_WIDTH-1:0]        rdata_q;

    // Pattern 01 of the sampled pair marks a valid read strobe
    assign strobe_o = read_en_i && (rwds_i == 2'b01);

    // Last allowed cycle in read without a strobe
    assign timeout_o = read_en_i && (wait_q == LAST_CYCLE);

    // Cycles spent waiting in read, restarts whenever read_en_i drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q <= '0;
        end else if (!read_en_i) begin
            wait_q <= '0;
        end else if (wait_q != LAST_CYCLE) begin
            wait_q <= wait_q + 1'b1;
        end
    end

    // Read word, held until the next strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q <= '0;
        end else if (strobe_o) begin
            rdata_q <= dq_i;
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/hbus_sequencer.sv
`timescale 1ns/1ps

module hbus_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rrq_i,
    input  logic                    wrq_i,
    input  logic [1:0]              rwds_i,
    input  logic                    strobe_i,
    input  logic                    timeout_i,
    output logic                    load_o,
    output logic                    step_o,
    output logic                    read_en_o,
    output hbus_pkg::hbus_state_e   state_o,
    output logic                    dq_sel_wdata_o,
    output logic                    clk_en_o,
    output logic                    dq_oe_o
);

    // Count loads, the FSM leaves a phase when the counter reaches zero
    localparam hbus_pkg::seq_count_t CNT_RESET =
        hbus_pkg::seq_count_t'(hbus_pkg::RESET_COUNT);
    localparam hbus_pkg::seq_count_t CNT_RECOVERY =
        hbus_pkg::seq_count_t'(hbus_pkg::RECOVERY_COUNT);
    localparam hbus_pkg::seq_count_t CNT_COMMAND =
        hbus_pkg::seq_count_t'(2);
    localparam hbus_pkg::seq_count_t CNT_LAT_1X =
        hbus_pkg::seq_count_t'(hbus_pkg::TACC_COUNT - 1);
    localparam hbus_pkg::seq_count_t CNT_LAT_2X =
        hbus_pkg::seq_count_t'(2 * hbus_pkg::TACC_COUNT - 1);

    hbus_pkg::hbus_state_e      state_q;
    hbus_pkg::seq_count_t       count_q;
    logic                       read_q;
    logic                       count_zero;
    logic                       take_req;

    assign count_zero = (count_q == '0);

    // Requests are taken only once recovery has run out
    assign take_req = (state_q == hbus_pkg::IDLE) && count_zero && (rrq_i || wrq_i);

    assign load_o    = take_req;
    // Shift after every command word except the last
    assign step_o    = (state_q == hbus_pkg::COMMAND) && !count_zero;
    assign read_en_o = (state_q == hbus_pkg::READ);

    assign dq_sel_wdata_o = (state_q == hbus_pkg::WRITE);
    assign dq_oe_o  = (state_q == hbus_pkg::COMMAND) || (state_q == hbus_pkg::WRITE);
    assign clk_en_o = (state_q == hbus_pkg::COMMAND) || (state_q == hbus_pkg::LATENCY) ||
                      (state_q == hbus_pkg::READ) || (state_q == hbus_pkg::WRITE);

    assign state_o = state_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= hbus_pkg::RESET;
            count_q <= CNT_RESET;
            read_q  <= 1'b0;
        end else begin
            case (state_q)
                hbus_pkg::RESET: begin
                    // Bus reset held low until the count runs out
                    if (count_zero) begin
                        state_q <= hbus_pkg::IDLE;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end

                hbus_pkg::IDLE: begin
                    if (take_req) begin
                        // Read wins when both strobes are up
                        read_q  <= rrq_i;
                        count_q <= CNT_COMMAND;
                        state_q <= hbus_pkg::COMMAND;
                    end else if (!count_zero) begin
                        count_q <= count_q - 1'b1;
                    end
                end

                hbus_pkg::COMMAND: begin
                    if (count_zero) begin
                        // RWDS high on both halves asks for doubled latency
                        if (rwds_i == 2'b11) begin
                            count_q <= CNT_LAT_2X;
                        end else begin
                            count_q <= CNT_LAT_1X;
                        end
                        state_q <= hbus_pkg::LATENCY;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end

                hbus_pkg::LATENCY: begin
                    if (count_zero) begin
                        state_q <= read_q ? hbus_pkg::READ : hbus_pkg::WRITE;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end

                hbus_pkg::READ: begin
                    if (strobe_i) begin
                        count_q <= CNT_RECOVERY;
                        state_q <= hbus_pkg::IDLE;
                    end else if (timeout_i) begin
                        state_q <= hbus_pkg::ERROR;
                    end
                end

                hbus_pkg::WRITE: begin
                    // Single word written, chip select goes high next
                    count_q <= CNT_RECOVERY;
                    state_q <= hbus_pkg::IDLE;
                end

                hbus_pkg::ERROR: begin
                    // Sticky until rst
                    state_q <= hbus_pkg::ERROR;
                end

                default: begin
                    count_q <= CNT_RESET;
                    state_q <= hbus_pkg::RESET;
                end
            endcase
        end
    end

endmodule

// File: testbench/hyperram_model.sv
`timescale 1ns/1ps

module hyperram_model (
    input  logic                                clk,
    input  logic                                rst,
    // Model controls from the testbench
    input  logic                                double_lat_i,
    input  logic                                mute_i,
    input  logic [3:0]                          delay_i,
    // Controller bus side
    input  logic                                csn_i,
    input  logic [hbus_pkg::WORD_WIDTH-1:0]     dq_i,
    input  logic                                dq_oe_i,
    output logic [hbus_pkg::WORD_WIDTH-1:0]     dq_o,
    output logic [1:0]                          rwds_o
);

    logic [5:0]                         cnt_q;
    logic [hbus_pkg::CA_WIDTH-1:0]      ca_q;
    logic [31:0]                        addr;
    int                                 read_cycle;

    // Address-derived read data
    function automatic logic [15:0] addr_pattern(input logic [31:0] a);
        return a[15:0] ^ a[31:16] ^ 16'hc35a;
    endfunction

    // Cycles with chip select low, command words shifted in on the first three
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            ca_q  <= '0;
        end else if (csn_i) begin
            cnt_q <= '0;
        end else begin
            if (cnt_q < 6'd3 && dq_oe_i) begin
                ca_q <= {ca_q[31:0], dq_i};
            end
            if (cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign addr = {ca_q[44:16], ca_q[2:0]};

    always_comb begin
        read_cycle = 3 + (double_lat_i ? 2 * hbus_pkg::TACC_COUNT : hbus_pkg::TACC_COUNT)
                     + int'(delay_i);
        rwds_o = 2'b00;
        dq_o   = '0;
        if (!csn_i && cnt_q < 6'd3 && double_lat_i) begin
            // Ask for doubled latency during command
            rwds_o = 2'b11;
        end else if (!csn_i && ca_q[47] && !mute_i && int'(cnt_q) == read_cycle) begin
            rwds_o = 2'b01;
            dq_o   = addr_pattern(addr);
        end
    end

endmodule

// File: testbench/tb_hbus_ctrl.sv
`timescale 1ns/1ps

module tb_hbus_ctrl;

    localparam int CYCLE_LIMIT = 20 * 60 + 2 * (8 + hbus_pkg::RESET_COUNT + 1) + 20;

    logic        clk;
    logic        rst;
    logic        rrq;
    logic        wrq;
    logic        reg_space;
    logic [31:0] adr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        rdata_valid;
    logic        busy;
    logic        error;
    logic        csn_o;
    logic        rstn_o;
    logic        clk_en_o;
    logic [15:0] dq_o;
    logic        dq_oe_o;
    logic [15:0] dq_i;
    logic [1:0]  rwds_i;
    logic        double_lat;
    logic        mute;
    logic [3:0]  delay;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          idle_seen = 0;
    logic [31:0] rng_state = 32'd62245;

    hbus_ctrl dut (
        .clk(clk), .rst(rst), .rrq_i(rrq), .wrq_i(wrq), .reg_space_i(reg_space),
        .adr_i(adr), .wdata_i(wdata), .rdata_o(rdata), .rdata_valid_o(rdata_valid),
        .busy_o(busy), .error_o(error), .csn_o(csn_o), .rstn_o(rstn_o),
        .clk_en_o(clk_en_o), .dq_o(dq_o), .dq_oe_o(dq_oe_o), .dq_i(dq_i), .rwds_i(rwds_i)
    );

    hyperram_model u_ram (
        .clk(clk), .rst(rst), .double_lat_i(double_lat), .mute_i(mute), .delay_i(delay),
        .csn_i(csn_o), .dq_i(dq_o), .dq_oe_i(dq_oe_o), .dq_o(dq_i), .rwds_o(rwds_i)
    );

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("The run hung: no progress after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Error is sticky
    assert property (@(posedge clk) disable iff (rst) error |=> error)
        else begin
            errors++;
            $display("error %0t: error_o dropped without reset", $time);
        end

    // Bus driven only inside a transaction
    assert property (@(posedge clk) disable iff (rst) dq_oe_o |-> (!csn_o && clk_en_o))
        else begin
            errors++;
            $display("error %0t: dq_oe_o high outside a transaction", $time);
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] expected_read_word(input logic [31:0] a);
        return a[15:0] ^ a[31:16] ^ 16'hc35a;
    endfunction

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error %0t: %s", $time, msg);
        end
    endtask

    // Next cycle, just after the edge
    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) begin
            tick();
            check(!rstn_o && csn_o && busy && !clk_en_o && !dq_oe_o && !error,
                  "bus outputs wrong during reset");
        end
        rst = 1'b0;
        check(!rstn_o && csn_o && busy, "bus reset released early");
        repeat (hbus_pkg::RESET_COUNT) begin
            tick();
            check(!rstn_o && csn_o && busy && !clk_en_o && !error,
                  "bus reset released early");
        end
        tick();
        check(rstn_o && !busy, "bus reset not released");
        idle_seen = 0;
    endtask

    task automatic run_txn(input logic rd, input logic regsp, input logic [31:0] a,
                           input logic [15:0] wd, input logic dbl, input logic [3:0] dly,
                           input logic mt, input logic after_txn);
        hbus_pkg::hbus_ca_t ca_exp;
        logic [47:0]        ca_seen;
        int                 idle_cnt;
        int                 lat;
        int                 lat_cnt;
        int                 wait_cnt;
        lat = dbl ? 2 * hbus_pkg::TACC_COUNT : hbus_pkg::TACC_COUNT;
        ca_exp.rw           = rd;
        ca_exp.addr_space   = regsp;
        ca_exp.burst_linear = 1'b0;
        ca_exp.row_col_hi   = a[31:3];
        ca_exp.reserved     = '0;
        ca_exp.col_lo       = a[2:0];
        double_lat = dbl;
        mute       = mt;
        delay      = dly;
        rrq        = rd;
        wrq        = !rd;
        reg_space  = regsp;
        adr        = a;
        wdata      = wd;
        ca_seen    = '0;
        idle_cnt   = (idle_seen > 0) ? idle_seen : 1;
        if (after_txn) begin
            check(busy, "busy_o low during recovery");
        end
        tick();
        while (csn_o) begin
            idle_cnt++;
            if (after_txn) begin
                check(busy == (idle_cnt <= hbus_pkg::RECOVERY_COUNT),
                      "busy_o wrong around recovery");
            end
            tick();
        end
        if (after_txn) begin
            check(idle_cnt == hbus_pkg::RECOVERY_COUNT + 1, "request taken out of recovery");
        end
        rrq = 1'b0;
        wrq = 1'b0;
        for (int k = 0; k < 3; k++) begin
            check(dq_oe_o && clk_en_o && !csn_o && busy, "command phase controls wrong");
            ca_seen = {ca_seen[31:0], dq_o};
            if (k < 2) begin
                tick();
            end
        end
        check(ca_seen == ca_exp, "command/address words wrong");
        if (!rd) begin
            lat_cnt = 0;
            tick();
            while (!dq_oe_o && !csn_o) begin
                lat_cnt++;
                tick();
            end
            check(lat_cnt == lat, "write latency wrong");
            check(dq_oe_o && dq_o == wd, "write word wrong");
            tick();
            check(csn_o, "chip select not raised after write");
            idle_seen = 1;
        end else begin
            wait_cnt = 0;
            do begin
                tick();
                wait_cnt++;
            end while (!rdata_valid && !error);
            if (mt) begin
                check(error && wait_cnt == lat + hbus_pkg::TIMEOUT_COUNT + 1,
                      "read timeout not flagged at the limit");
            end else begin
                check(!error && wait_cnt == lat + int'(dly) + 2, "read strobe timing wrong");
                check(rdata == expected_read_word(a), "read data wrong");
                tick();
                check(!rdata_valid, "rdata_valid_o longer than one cycle");
                idle_seen = 2;
            end
        end
    endtask

    initial begin
        logic rd;
        clk = 1'b0;
        rst = 1'b1;
        rrq = 1'b0;
        wrq = 1'b0;
        reg_space = 1'b0;
        adr = '0;
        wdata = '0;
        double_lat = 1'b0;
        mute = 1'b0;
        delay = '0;
        apply_reset();
        for (int i = 0; i < 16; i++) begin
            rng_state = xorshift(rng_state);
            adr = rng_state;
            rng_state = xorshift(rng_state);
            rd = i[0];
            run_txn(rd, rng_state[20], adr, rng_state[15:0], rng_state[24],
                    rng_state[30:28], 1'b0, i > 0);
        end
        // Silent memory, read must end in error
        rng_state = xorshift(rng_state);
        run_txn(1'b1, 1'b0, rng_state, 16'h0, 1'b0, 4'd0, 1'b1, 1'b1);
        rrq = 1'b1;
        repeat (10) begin
            tick();
            check(error && csn_o, "bus active after error");
        end
        rrq = 1'b0;
        apply_reset();
        check(!error, "error_o not cleared by reset");
        rng_state = xorshift(rng_state);
        run_txn(1'b0, 1'b1, rng_state, rng_state[31:16], 1'b1, 4'd0, 1'b0, 1'b0);
        rng_state = xorshift(rng_state);
        run_txn(1'b1, 1'b1, rng_state, 16'h0, 1'b1, 4'd5, 1'b0, 1'b1);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
